/* sim.f */
+incdir+design
design/cpu_pkg.sv
design/reg_file.sv
design/alu.sv
design/cpu_control.sv
design/cpu.sv
test/cpu_asserts.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f sim.f -Mdir obj_dir -o cpu_tb_sim

# a failing run still leaves its log for the search below
./obj_dir/cpu_tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* test/cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb;

    import cpu_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_STEPS  = 1000;

    logic                   clock;
    logic                   rst;
    logic [`DATA_WIDTH-1:0] data;
    logic [`DATA_WIDTH-1:0] data_out;
    logic [`DATA_WIDTH-1:0] address;
    logic                   rw;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lcg_state;
    int          gen_pc;
    int          err_count;
    int          watchdog_ns;
    logic        model_ready;

    // expected trace with one entry per executed instruction
    logic [31:0] exp_fetch [$];
    logic        exp_is_store [$];
    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    logic        cur_is_store;
    logic [31:0] cur_store_addr;
    logic [31:0] cur_store_data;

    cpu u_dut (
        .clock    (clock),
        .rst      (rst),
        .data     (data),
        .data_out (data_out),
        .address  (address),
        .rw       (rw)
    );

    // memory answers within the same cycle
    assign data = (address < MEM_WORDS) ? mem[address[7:0]] : '0;

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] reg_word(opcode_t op, logic [2:0] ra, logic [2:0] rb,
                                             logic [2:0] rd, logic hl, logic [15:0] value);
        return {value, hl, rd, rb, ra, op};
    endfunction

    function automatic logic [31:0] jump_word(opcode_t op, logic [2:0] fsel,
                                              logic [22:0] target);
        return {target, fsel, op};
    endfunction

    task automatic put_word(input logic [31:0] w);
        mem[gen_pc[7:0]] = w;
        gen_pc++;
    endtask

    task automatic load_const(input logic [2:0] rd, input logic [31:0] val);
        put_word(reg_word(LOADI, 3'd0, 3'd0, rd, 1'b0, val[15:0]));
        // rb names rd because the high half keeps the low half of rb
        put_word(reg_word(LOADI, 3'd0, rd, rd, 1'b1, val[31:16]));
    endtask

    task automatic build_program();
        opcode_t     ops [5];
        logic [31:0] v;
        ops = '{ADD, SUB, AND, OR, XOR};
        // every unused word is a jump to itself
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            mem[a[7:0]] = jump_word(JMP, 3'd0, 23'(a));
        end
        gen_pc = 0;
        for (int i = 0; i < 5; i++)
        begin
            load_const(3'd1, lcg_next());
            load_const(3'd2, lcg_next());
            put_word(reg_word(STORE, 3'd0, 3'd1, 3'd0, 1'b0, 16'h0200 + 16'(i)));
            put_word(reg_word(ops[i], 3'd1, 3'd2, 3'd3, 1'b0, 16'h0000));
            put_word(reg_word(STORE, 3'd0, 3'd3, 3'd0, 1'b0, 16'h0100 + 16'(i)));
        end
        v = lcg_next();
        load_const(3'd4, v);
        load_const(3'd5, v);
        put_word(reg_word(CMPEQ, 3'd4, 3'd5, 3'd2, 1'b0, 16'h0000));
        put_word(jump_word(BRF, 3'd2, 23'(gen_pc + 2)));
        put_word(reg_word(STORE, 3'd0, 3'd4, 3'd0, 1'b0, 16'h0300));
        // equal operands leave this flag clear and the store runs
        put_word(reg_word(CMPLT, 3'd4, 3'd5, 3'd3, 1'b0, 16'h0000));
        put_word(jump_word(BRF, 3'd3, 23'(gen_pc + 2)));
        put_word(reg_word(STORE, 3'd0, 3'd5, 3'd0, 1'b0, 16'h0301));
        put_word(reg_word(CMPLT, 3'd1, 3'd2, 3'd6, 1'b0, 16'h0000));
        put_word(jump_word(BRF, 3'd6, 23'(gen_pc + 2)));
        put_word(reg_word(STORE, 3'd0, 3'd1, 3'd0, 1'b0, 16'h0302));
        put_word(jump_word(JMP, 3'd0, 23'(gen_pc + 2)));
        put_word(reg_word(STORE, 3'd0, 3'd2, 3'd0, 1'b0, 16'h0303));
        put_word(jump_word(JMP, 3'd0, 23'(gen_pc)));
    endtask

    // instruction set model that stops at the first jump to itself
    task automatic run_model();
        logic [31:0] regs [8];
        logic [7:0]  flags;
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] w;
        logic [5:0]  op;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic        taken;
        logic        done;
        int          steps;
        for (int r = 0; r < 8; r++)
        begin
            regs[r] = '0;
        end
        flags = '0;
        pc = `RESET_ADDR;
        done = 1'b0;
        steps = 0;
        while (!done && steps < MAX_STEPS)
        begin
            w = mem[pc[7:0]];
            op = w[5:0];
            ra = w[8:6];
            rb = w[11:9];
            rd = w[14:12];
            a = regs[ra];
            b = regs[rb];
            exp_fetch.push_back(pc);
            exp_is_store.push_back(op == STORE);
            exp_store_addr.push_back({16'h0000, w[31:16]});
            exp_store_data.push_back(b);
            taken = 1'b0;
            case (op)
                ADD:     regs[rd] = a + b;
                SUB:     regs[rd] = a - b;
                AND:     regs[rd] = a & b;
                OR:      regs[rd] = a | b;
                XOR:     regs[rd] = a ^ b;
                LOADI:   regs[rd] = w[15] ? {w[31:16], b[15:0]} : {16'h0000, w[31:16]};
                CMPEQ:   flags[rd] = (a == b);
                CMPLT:   flags[rd] = (a < b);
                BRF:     taken = flags[ra];
                JMP:     taken = 1'b1;
                default: ;
            endcase
            pc_next = taken ? {9'h000, w[31:9]} : pc + 32'd1;
            done = (pc_next == pc);
            pc = pc_next;
            steps++;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        err_count++;
        $display("Error at %0t: %s expected %h, got %h", $time, name, want, got);
    endtask

    task automatic check_fetch();
        logic [31:0] want;
        want = exp_fetch.pop_front();
        cur_is_store = exp_is_store.pop_front();
        cur_store_addr = exp_store_addr.pop_front();
        cur_store_data = exp_store_data.pop_front();
        assert (address == want) else report_mismatch("address", want, address);
        assert (rw == 1'b1) else report_mismatch("rw", 32'd1, 32'(rw));
    endtask

    task automatic check_execute();
        if (cur_is_store)
        begin
            assert (rw == 1'b0) else report_mismatch("rw", 32'd0, 32'(rw));
            assert (address == cur_store_addr)
                else report_mismatch("address", cur_store_addr, address);
            assert (data_out == cur_store_data)
                else report_mismatch("data_out", cur_store_data, data_out);
        end
        else
        begin
            assert (rw == 1'b1) else report_mismatch("rw", 32'd1, 32'(rw));
        end
    endtask

    initial
    begin
        rst = 1'b1;
        model_ready = 1'b0;
        err_count = 0;
        lcg_state = 32'd46;
        build_program();
        run_model();
        watchdog_ns = (exp_fetch.size() + 16) * 3 * CLK_PERIOD + 4 * CLK_PERIOD;
        model_ready = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        // outputs are sampled mid-cycle in groups of three per instruction
        while (exp_fetch.size() > 0)
        begin
            check_fetch();
            @(negedge clock);
            check_execute();
            @(negedge clock);
            assert (rw == 1'b1) else report_mismatch("rw", 32'd1, 32'(rw));
            @(negedge clock);
        end
        $display("errors: %0d in checks, %0d in bound assertions",
                 err_count, u_dut.u_asserts.fail_count);
        if (err_count == 0 && u_dut.u_asserts.fail_count == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial
    begin
        wait (model_ready);
        #(watchdog_ns);
        $display("timeout: the program never reached its final jump");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* test/cpu_asserts.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_asserts (
    input logic                   clock,
    input logic                   rst,
    input logic [`DATA_WIDTH-1:0] address,
    input logic                   rw,
    input logic                   take_branch,
    input logic [`DATA_WIDTH-1:0] branch_target
);

    int unsigned fail_count = 0;
    logic [1:0]  phase;

    // position inside the three-cycle group, 0 is fetch
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            phase <= 2'd0;
        end
        else if (phase == 2'd2)
        begin
            phase <= 2'd0;
        end
        else
        begin
            phase <= phase + 2'd1;
        end
    end

    reset_fetch: assert property (@(posedge clock)
        $fell(rst) |-> (address == `RESET_ADDR) && rw)
    else
    begin
        fail_count++;
        $error("first fetch after reset is not a read of the reset address");
    end

    store_one_cycle: assert property (@(posedge clock) disable iff (rst)
        !rw |=> rw)
    else
    begin
        fail_count++;
        $error("rw stayed low for more than one cycle");
    end

    store_in_execute: assert property (@(posedge clock) disable iff (rst)
        !rw |-> phase == 2'd1)
    else
    begin
        fail_count++;
        $error("rw went low outside the middle cycle of an instruction");
    end

    // sequential code fetches the next word three cycles on
    fetch_sequential: assert property (@(posedge clock) disable iff (rst)
        (phase == 2'd2 && !take_branch) |=> address == $past(address, 3) + 32'd1)
    else
    begin
        fail_count++;
        $error("fetch address is not the previous one plus one");
    end

    fetch_branch: assert property (@(posedge clock) disable iff (rst)
        (phase == 2'd2 && take_branch) |=> address == $past(branch_target))
    else
    begin
        fail_count++;
        $error("taken branch did not fetch from its target");
    end

endmodule

bind cpu cpu_asserts u_asserts (
    .clock         (clock),
    .rst           (rst),
    .address       (address),
    .rw            (rw),
    .take_branch   (take_branch),
    .branch_target (branch_target)
);

/* design/cpu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [`DATA_WIDTH-1:0] data,
    output logic [`DATA_WIDTH-1:0] data_out,
    output logic [`DATA_WIDTH-1:0] address,
    output logic                   rw
);

    import cpu_pkg::*;

    instr_t                 instr;
    logic                   reg_write;
    logic                   flag_write;
    logic [`DATA_WIDTH-1:0] reg_a;
    logic [`DATA_WIDTH-1:0] reg_b;
    logic                   flag_sel_value;
    logic [`DATA_WIDTH-1:0] result;
    logic                   flag_result;
    logic                   take_branch;
    logic [`DATA_WIDTH-1:0] branch_target;

    cpu_control u_control (
        .clock         (clock),
        .rst           (rst),
        .data          (data),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .reg_b         (reg_b),
        .instr         (instr),
        .reg_write     (reg_write),
        .flag_write    (flag_write),
        .address       (address),
        .data_out      (data_out),
        .rw            (rw)
    );

    // flag select of the jump view lands on ra
    reg_file u_reg_file (
        .clock          (clock),
        .rst            (rst),
        .ra             (instr.r.ra),
        .rb             (instr.r.rb),
        .rd             (instr.r.rd),
        .reg_write      (reg_write),
        .flag_write     (flag_write),
        .write_data     (result),
        .flag_in        (flag_result),
        .reg_a          (reg_a),
        .reg_b          (reg_b),
        .flag_sel_value (flag_sel_value)
    );

    alu u_alu (
        .instr          (instr),
        .reg_a          (reg_a),
        .reg_b          (reg_b),
        .flag_sel_value (flag_sel_value),
        .result         (result),
        .flag_result    (flag_result),
        .take_branch    (take_branch),
        .branch_target  (branch_target)
    );

endmodule

/* design/cpu_control.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_control (
    input  logic                   clock,
    input  logic                   rst,
    input  logic [`DATA_WIDTH-1:0] data,
    input  logic                   take_branch,
    input  logic [`DATA_WIDTH-1:0] branch_target,
    input  logic [`DATA_WIDTH-1:0] reg_b,
    output cpu_pkg::instr_t        instr,
    output logic                   reg_write,
    output logic                   flag_write,
    output logic [`DATA_WIDTH-1:0] address,
    output logic [`DATA_WIDTH-1:0] data_out,
    output logic                   rw
);

    import cpu_pkg::*;

    seq_state_t             state;
    seq_state_t             state_next;
    instr_t                 ir;
    logic [`DATA_WIDTH-1:0] pc;
    logic                   is_store;

    always_comb
    begin
        case (state)
            FETCH:   state_next = EXECUTE;
            EXECUTE: state_next = UPDATE;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= FETCH;
        end
        else
        begin
            state <= state_next;
        end
    end

    // memory answers in the same cycle, so capture at the end of fetch
    always_ff @(posedge clock)
    begin
        if (state == FETCH)
        begin
            ir <= data;
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= `RESET_ADDR;
        end
        else if (state == UPDATE)
        begin
            if (take_branch)
            begin
                pc <= branch_target;
            end
            else
            begin
                pc <= pc + 1'b1;
            end
        end
    end

    // strobes only live in execute
    always_comb
    begin
        reg_write  = 1'b0;
        flag_write = 1'b0;
        is_store   = 1'b0;
        if (state == EXECUTE)
        begin
            case (ir.r.opcode)
                ADD, SUB, AND, OR, XOR, LOADI: reg_write = 1'b1;
                CMPEQ, CMPLT:                  flag_write = 1'b1;
                STORE:                         is_store = 1'b1;
                default: ;
            endcase
        end
    end

    // pc on the bus except for the one store cycle
    assign address  = is_store ? `DATA_WIDTH'(ir.r.value) : pc;
    assign data_out = is_store ? reg_b : '0;
    assign rw       = ~is_store;
    assign instr    = ir;

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
    input  cpu_pkg::instr_t        instr,
    input  logic [`DATA_WIDTH-1:0] reg_a,
    input  logic [`DATA_WIDTH-1:0] reg_b,
    input  logic                   flag_sel_value,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   flag_result,
    output logic                   take_branch,
    output logic [`DATA_WIDTH-1:0] branch_target
);

    import cpu_pkg::*;

    localparam int HALF = `DATA_WIDTH / 2;

    logic [`DATA_WIDTH-1:0] loadi_word;

    // loadi high keeps the low half of rb, so programs name rd as rb
    always_comb
    begin
        if (instr.r.highlow)
        begin
            loadi_word = {instr.r.value, reg_b[HALF-1:0]};
        end
        else
        begin
            loadi_word = `DATA_WIDTH'(instr.r.value);
        end
    end

    // register view decode
    always_comb
    begin
        result      = '0;
        flag_result = 1'b0;
        case (instr.r.opcode)
            ADD:     result = reg_a + reg_b;
            SUB:     result = reg_a - reg_b;
            AND:     result = reg_a & reg_b;
            OR:      result = reg_a | reg_b;
            XOR:     result = reg_a ^ reg_b;
            LOADI:   result = loadi_word;
            CMPEQ:   flag_result = (reg_a == reg_b);
            // unsigned compare
            CMPLT:   flag_result = (reg_a < reg_b);
            default: result = '0;
        endcase
    end

    // jump view decode
    always_comb
    begin
        case (instr.j.opcode)
            JMP:     take_branch = 1'b1;
            BRF:     take_branch = flag_sel_value;
            default: take_branch = 1'b0;
        endcase
    end

    // word address, no offset from pc
    assign branch_target = `DATA_WIDTH'(instr.j.target);

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module reg_file (
    input  logic                      clock,
    input  logic                      rst,
    input  logic [`REG_IDX_WIDTH-1:0] ra,
    input  logic [`REG_IDX_WIDTH-1:0] rb,
    input  logic [`REG_IDX_WIDTH-1:0] rd,
    input  logic                      reg_write,
    input  logic                      flag_write,
    input  logic [`DATA_WIDTH-1:0]    write_data,
    input  logic                      flag_in,
    output logic [`DATA_WIDTH-1:0]    reg_a,
    output logic [`DATA_WIDTH-1:0]    reg_b,
    output logic                      flag_sel_value
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
    logic [`NUM_REGS-1:0]   flags;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (reg_write)
        begin
            regs[rd] <= write_data;
        end
    end

    // flags share the rd index with the registers
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            flags <= '0;
        end
        else if (flag_write)
        begin
            flags[rd] <= flag_in;
        end
    end

    // reads are combinational, a write shows up after the edge
    assign reg_a          = regs[ra];
    assign reg_b          = regs[rb];
    assign flag_sel_value = flags[ra];

endmodule

/* design/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [5:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,
        SUB   = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        XOR   = 6'd5,
        LOADI = 6'd6,
        CMPEQ = 6'd7,
        CMPLT = 6'd8,
        STORE = 6'd9,
        BRF   = 6'd10,
        JMP   = 6'd11
    } opcode_t;

    // one instruction takes one pass through all three states
    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        UPDATE  = 2'd2
    } seq_state_t;

    // register form, used by alu ops, compares, loadi and store
    typedef struct packed {
        logic [15:0]               value;
        logic                      highlow;
        logic [`REG_IDX_WIDTH-1:0] rd;
        logic [`REG_IDX_WIDTH-1:0] rb;
        logic [`REG_IDX_WIDTH-1:0] ra;
        opcode_t                   opcode;
    } reg_view_t;

    // jump form, the flag select sits on the ra bits
    typedef struct packed {
        logic [22:0]               target;
        logic [`REG_IDX_WIDTH-1:0] flag_sel;
        opcode_t                   opcode;
    } jump_view_t;

    typedef union packed {
        reg_view_t  r;
        jump_view_t j;
    } instr_t;

endpackage

/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// machine word, also the width of every general register
`define DATA_WIDTH 32

// general registers and one-bit flags come in the same count
`define NUM_REGS 8

// index width for ra, rb, rd and the flag select
`define REG_IDX_WIDTH 3

// first fetch after reset
`define RESET_ADDR 32'h0000_0000

`endif
